// ==== logic/core_pkg.sv ====
// RV32I integer subset only; XLEN is fixed at 32 since all stage bundles are packed structs
package core_pkg;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN        = 32;
  localparam int AR_BITS     = 5;
  localparam int PARCEL_SIZE = 32;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_SUB = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  //////////////////////////////////////////////////
  // Instruction word views

  typedef struct packed {
    logic [6:0]         funct7;
    logic [AR_BITS-1:0] rs2;
    logic [AR_BITS-1:0] rs1;
    logic [2:0]         funct3;
    logic [AR_BITS-1:0] rd;
    logic [6:0]         opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]        imm;
    logic [AR_BITS-1:0] rs1;
    logic [2:0]         funct3;
    logic [AR_BITS-1:0] rd;
    logic [6:0]         opcode;
  } i_fmt_t;

  // Same 32 bits, rs2/funct7 in one view and imm in the other
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

  //////////////////////////////////////////////////
  // Stage bundles

  typedef struct packed {
    logic            bubble;
    logic [XLEN-1:0] pc;
    instr_t          instr;
  } if_id_t;

  // opa/opb already carry bypassed values
  typedef struct packed {
    logic               bubble;
    logic [XLEN-1:0]    pc;
    alu_op_e            alu_op;
    logic [AR_BITS-1:0] rd;
    logic               we;
    logic [XLEN-1:0]    opa;
    logic [XLEN-1:0]    opb;
  } id_ex_t;

  typedef struct packed {
    logic               we;
    logic [AR_BITS-1:0] dst;
    logic [XLEN-1:0]    r;
    logic [XLEN-1:0]    pc;
  } wb_t;

endpackage

// ==== logic/riscv_core.sv ====
// No branches, loads/stores, CSRs or exceptions; fixed 3-stage latency with no back-pressure
module riscv_core #(
  parameter logic [core_pkg::XLEN-1:0] PC_INIT = 'h200
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Instruction fetch
  input  logic [core_pkg::PARCEL_SIZE-1:0] if_parcel_i,
  input  logic                             if_parcel_valid_i,
  output logic [core_pkg::XLEN-1:0]        if_nxt_pc_o,

  // Write-back observation port
  output logic                             wb_we_o,
  output logic [core_pkg::AR_BITS-1:0]     wb_dst_o,
  output logic [core_pkg::XLEN-1:0]        wb_r_o,
  output logic [core_pkg::XLEN-1:0]        wb_pc_o
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // Stage wires

  core_pkg::if_id_t             if_id;
  core_pkg::id_ex_t             id_ex;
  core_pkg::wb_t                wb;
  logic [core_pkg::XLEN-1:0]    ex_r;

  logic [core_pkg::AR_BITS-1:0] rf_src1;
  logic [core_pkg::AR_BITS-1:0] rf_src2;
  logic [core_pkg::XLEN-1:0]    rf_srcv1;
  logic [core_pkg::XLEN-1:0]    rf_srcv2;

  //////////////////////////////////////////////////
  // Pipeline

  riscv_if #(
    .PC_INIT ( PC_INIT )
  ) if_unit (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .if_parcel_i       ( if_parcel_i       ),
    .if_parcel_valid_i ( if_parcel_valid_i ),
    .if_nxt_pc_o       ( if_nxt_pc_o       ),
    .if_id_o           ( if_id             )
  );

  riscv_id id_unit (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .if_id_i    ( if_id    ),
    .rf_src1_o  ( rf_src1  ),
    .rf_src2_o  ( rf_src2  ),
    .rf_srcv1_i ( rf_srcv1 ),
    .rf_srcv2_i ( rf_srcv2 ),
    .ex_fwd_i   ( id_ex    ),
    .ex_fwd_r_i ( ex_r     ),
    .wb_i       ( wb       ),
    .id_ex_o    ( id_ex    )
  );

  riscv_ex ex_unit (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .id_ex_i ( id_ex   ),
    .ex_r_o  ( ex_r    ),
    .wb_o    ( wb      )
  );

  riscv_rf rf_unit (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .rf_src1_i  ( rf_src1  ),
    .rf_src2_i  ( rf_src2  ),
    .rf_srcv1_o ( rf_srcv1 ),
    .rf_srcv2_o ( rf_srcv2 ),
    .wb_i       ( wb       )
  );

  assign wb_we_o  = wb.we;
  assign wb_dst_o = wb.dst;
  assign wb_r_o   = wb.r;
  assign wb_pc_o  = wb.pc;

endmodule

// ==== logic/riscv_ex.sv ====
// Single-cycle ALU; the registered result is the only write-back source
module riscv_ex (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  core_pkg::id_ex_t          id_ex_i,
  output logic [core_pkg::XLEN-1:0] ex_r_o,
  output core_pkg::wb_t             wb_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [core_pkg::XLEN-1:0]    alu_r;
  logic                         wb_we_q;
  logic [core_pkg::AR_BITS-1:0] wb_dst_q;
  logic [core_pkg::XLEN-1:0]    wb_r_q;
  logic [core_pkg::XLEN-1:0]    wb_pc_q;

  //////////////////////////////////////////////////
  // ALU

  always_comb begin
    case (id_ex_i.alu_op)
      core_pkg::ALU_SUB: alu_r = id_ex_i.opa - id_ex_i.opb;
      core_pkg::ALU_AND: alu_r = id_ex_i.opa & id_ex_i.opb;
      core_pkg::ALU_OR:  alu_r = id_ex_i.opa | id_ex_i.opb;
      core_pkg::ALU_XOR: alu_r = id_ex_i.opa ^ id_ex_i.opb;
      default:           alu_r = id_ex_i.opa + id_ex_i.opb;
    endcase
  end

  // Also feeds the decode bypass
  assign ex_r_o = alu_r;

  //////////////////////////////////////////////////
  // Write-back register

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= id_ex_i.we & ~id_ex_i.bubble;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_dst_q <= id_ex_i.rd;
    wb_r_q   <= alu_r;
    wb_pc_q  <= id_ex_i.pc;
  end

  assign wb_o = '{we: wb_we_q, dst: wb_dst_q, r: wb_r_q, pc: wb_pc_q};

endmodule

// ==== logic/riscv_id.sv ====
// Decodes OP/OP-IMM ADD, SUB, AND, OR, XOR only; anything else leaves as a bubble
module riscv_id (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  core_pkg::if_id_t             if_id_i,
  output logic [core_pkg::AR_BITS-1:0] rf_src1_o,
  output logic [core_pkg::AR_BITS-1:0] rf_src2_o,
  input  logic [core_pkg::XLEN-1:0]    rf_srcv1_i,
  input  logic [core_pkg::XLEN-1:0]    rf_srcv2_i,
  input  core_pkg::id_ex_t             ex_fwd_i,
  input  logic [core_pkg::XLEN-1:0]    ex_fwd_r_i,
  input  core_pkg::wb_t                wb_i,
  output core_pkg::id_ex_t             id_ex_o
);
  timeunit 1ns;
  timeprecision 100ps;

  core_pkg::instr_t          instr;
  core_pkg::alu_op_e         alu_op;
  logic                      supported;
  logic                      use_imm;
  logic [core_pkg::XLEN-1:0] imm;
  logic [core_pkg::XLEN-1:0] opa;
  logic [core_pkg::XLEN-1:0] opb;
  logic                      ex_hit_ok;
  core_pkg::id_ex_t          id_ex_q;

  assign instr = if_id_i.instr;

  //////////////////////////////////////////////////
  // Decode

  always_comb begin
    supported = 1'b0;
    use_imm   = 1'b0;
    alu_op    = core_pkg::ALU_ADD;
    if (instr.r.opcode == core_pkg::OPC_OP) begin
      supported = (instr.r.funct7 == '0);
      case (instr.r.funct3)
        core_pkg::F3_ADD_SUB: begin
          alu_op    = (instr.r.funct7 == core_pkg::F7_SUB) ? core_pkg::ALU_SUB
                                                          : core_pkg::ALU_ADD;
          supported = (instr.r.funct7 == '0) || (instr.r.funct7 == core_pkg::F7_SUB);
        end
        core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
        core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
        core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
        default:          supported = 1'b0;
      endcase
    end else if (instr.i.opcode == core_pkg::OPC_OP_IMM) begin
      use_imm   = 1'b1;
      supported = 1'b1;
      case (instr.i.funct3)
        core_pkg::F3_ADD_SUB: alu_op = core_pkg::ALU_ADD;
        core_pkg::F3_XOR:     alu_op = core_pkg::ALU_XOR;
        core_pkg::F3_OR:      alu_op = core_pkg::ALU_OR;
        core_pkg::F3_AND:     alu_op = core_pkg::ALU_AND;
        default:              supported = 1'b0;
      endcase
    end
  end

  assign imm = {{(core_pkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};

  //////////////////////////////////////////////////
  // Operand bypass: EX first, then WB, then RF

  assign ex_hit_ok = ex_fwd_i.we & ~ex_fwd_i.bubble;

  function automatic logic [core_pkg::XLEN-1:0] sel_operand(
    input logic [core_pkg::AR_BITS-1:0] src,
    input logic [core_pkg::XLEN-1:0]    rf_val
  );
    logic [core_pkg::XLEN-1:0] val;
    if (ex_hit_ok && ex_fwd_i.rd == src) val = ex_fwd_r_i;
    else if (wb_i.we && wb_i.dst == src) val = wb_i.r;
    else val = rf_val;
    return val;
  endfunction

  assign rf_src1_o = instr.r.rs1;
  assign rf_src2_o = instr.r.rs2;

  always_comb begin
    opa = sel_operand(instr.r.rs1, rf_srcv1_i);
    opb = use_imm ? imm : sel_operand(instr.r.rs2, rf_srcv2_i);
  end

  // Control fields
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_ex_q.bubble <= 1'b1;
      id_ex_q.we     <= 1'b0;
    end else begin
      id_ex_q.bubble <= if_id_i.bubble | ~supported;
      id_ex_q.we     <= supported & (instr.r.rd != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    id_ex_q.pc     <= if_id_i.pc;
    id_ex_q.alu_op <= alu_op;
    id_ex_q.rd     <= instr.r.rd;
    id_ex_q.opa    <= opa;
    id_ex_q.opb    <= opb;
  end

  assign id_ex_o = id_ex_q;

endmodule

// ==== logic/riscv_if.sv ====
// Fetches sequentially from PC_INIT; PC only moves when a parcel is strobed in
module riscv_if #(
  parameter logic [core_pkg::XLEN-1:0] PC_INIT = 'h200
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [core_pkg::PARCEL_SIZE-1:0] if_parcel_i,
  input  logic                             if_parcel_valid_i,
  output logic [core_pkg::XLEN-1:0]        if_nxt_pc_o,
  output core_pkg::if_id_t                 if_id_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::XLEN-1:0] fetch_pc_q;
  core_pkg::instr_t          instr_q;
  logic                      bubble_q;

  // Program counter and bubble flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q     <= PC_INIT;
      bubble_q <= 1'b1;
    end else begin
      bubble_q <= ~if_parcel_valid_i;
      if (if_parcel_valid_i) begin
        pc_q <= pc_q + core_pkg::XLEN'(4);
      end
    end
  end

  // Fetch register, holds its last parcel while idle
  always_ff @(posedge clk_i) begin
    if (if_parcel_valid_i) begin
      instr_q    <= if_parcel_i;
      fetch_pc_q <= pc_q;
    end
  end

  assign if_nxt_pc_o = pc_q;
  assign if_id_o     = '{bubble: bubble_q, pc: fetch_pc_q, instr: instr_q};

endmodule

// ==== logic/riscv_rf.sv ====
// Two async read ports, one write port; x0 has no storage and reads as zero
module riscv_rf (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [core_pkg::AR_BITS-1:0] rf_src1_i,
  input  logic [core_pkg::AR_BITS-1:0] rf_src2_i,
  output logic [core_pkg::XLEN-1:0]    rf_srcv1_o,
  output logic [core_pkg::XLEN-1:0]    rf_srcv2_o,
  input  core_pkg::wb_t                wb_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [core_pkg::XLEN-1:0] regs [1:31];

  // Cleared on reset, written at the end of a write-back cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int n = 1; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (wb_i.we && wb_i.dst != '0) begin
      regs[wb_i.dst] <= wb_i.r;
    end
  end

  assign rf_srcv1_o = (rf_src1_i == '0) ? '0 : regs[rf_src1_i];
  assign rf_srcv2_o = (rf_src2_i == '0) ? '0 : regs[rf_src2_i];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sim.f --top-module tb_riscv_core

out=$(./obj_dir/Vtb_riscv_core)
echo "$out"

# Exit status of grep decides pass or fail
echo "$out" | grep -q "^STATUS: PASS$"

// ==== sim.f ====
logic/core_pkg.sv
logic/riscv_rf.sv
logic/riscv_if.sv
logic/riscv_id.sv
logic/riscv_ex.sv
logic/riscv_core.sv
test/tb_riscv_core.sv

// ==== test/tb_riscv_core.sv ====
// Random OP/OP-IMM stream on x0..x7 only; write-back expected two edges after the accepting edge
module tb_riscv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] PC_INIT      = 32'h200;
  localparam int          RESET_CYCLES = 10;
  localparam int          N_INSTR      = 300;
  localparam int          TIMEOUT      = RESET_CYCLES + N_INSTR * 2 + 50;
  localparam int unsigned SEED         = 53296;

  // Encodings used to build stimulus
  localparam logic [6:0] OPC_REG  = 7'b0110011;
  localparam logic [6:0] OPC_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] F7_ZERO  = 7'b0000000;
  localparam logic [6:0] F7_NEG   = 7'b0100000;

  typedef struct packed {
    logic        we;
    logic [4:0]  dst;
    logic [31:0] r;
    logic [31:0] pc;
  } exp_t;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] if_parcel_i;
  logic        if_parcel_valid_i;
  logic [31:0] if_nxt_pc_o;
  logic        wb_we_o;
  logic [4:0]  wb_dst_o;
  logic [31:0] wb_r_o;
  logic [31:0] wb_pc_o;

  logic [31:0] ref_regs [32];
  exp_t        drv_exp;
  exp_t        pipe [3];
  logic [31:0] exp_nxt_pc;
  int          errors;
  int          n_wb;
  int          n_exp_writes;
  int          cycles;

  riscv_core #(
    .PC_INIT ( PC_INIT )
  ) u_riscv_core (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .if_parcel_i       ( if_parcel_i       ),
    .if_parcel_valid_i ( if_parcel_valid_i ),
    .if_nxt_pc_o       ( if_nxt_pc_o       ),
    .wb_we_o           ( wb_we_o           ),
    .wb_dst_o          ( wb_dst_o          ),
    .wb_r_o            ( wb_r_o            ),
    .wb_pc_o           ( wb_pc_o           )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reference model

  // Builds one random instruction and retires it into the register model
  task automatic make_instruction(output logic [31:0] word, output exp_t res);
    int unsigned kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic        ok;
    kind = $urandom_range(0, 9);
    rd   = 5'($urandom_range(0, 7));
    rs1  = 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    imm  = 12'($urandom);
    a    = ref_regs[rs1];
    simm = {{20{imm[11]}}, imm};
    b    = (kind >= 5) ? simm : ref_regs[rs2];
    ok   = 1'b1;
    res  = '0;
    case (kind)
      0:       word = {F7_ZERO, rs2, rs1, 3'b000, rd, OPC_REG};
      1:       word = {F7_NEG, rs2, rs1, 3'b000, rd, OPC_REG};
      2:       word = {F7_ZERO, rs2, rs1, 3'b111, rd, OPC_REG};
      3:       word = {F7_ZERO, rs2, rs1, 3'b110, rd, OPC_REG};
      4:       word = {F7_ZERO, rs2, rs1, 3'b100, rd, OPC_REG};
      5:       word = {imm, rs1, 3'b000, rd, OPC_IMM};
      6:       word = {imm, rs1, 3'b111, rd, OPC_IMM};
      7:       word = {imm, rs1, 3'b110, rd, OPC_IMM};
      8:       word = {imm, rs1, 3'b100, rd, OPC_IMM};
      default: begin
        // Load, SLTI or SLL, none of which this core executes
        case (imm[1:0])
          2'b00:   word = {imm, rs1, 3'b010, rd, OPC_LOAD};
          2'b01:   word = {imm, rs1, 3'b010, rd, OPC_IMM};
          default: word = {F7_ZERO, rs2, rs1, 3'b001, rd, OPC_REG};
        endcase
      end
    endcase
    // ISA result of each operation
    case (kind)
      0, 5:    res.r = a + b;
      1:       res.r = a - b;
      2, 6:    res.r = a & b;
      3, 7:    res.r = a | b;
      4, 8:    res.r = a ^ b;
      default: ok = 1'b0;
    endcase
    res.we  = ok && (rd != 5'd0);
    res.dst = rd;
    if (res.we) begin
      ref_regs[rd] = res.r;
      n_exp_writes++;
    end
  endtask

  // Expected write-back, delayed like the three stages
  always @(posedge clk_i) begin : model_pipe
    exp_t entry;
    entry    = drv_exp;
    entry.pc = exp_nxt_pc;
    if (!if_parcel_valid_i) begin
      entry.we = 1'b0;
    end
    if (!rst_n_i) begin
      for (int k = 0; k < 3; k++) begin
        pipe[k] <= '0;
      end
      exp_nxt_pc <= PC_INIT;
    end else begin
      pipe[0] <= entry;
      pipe[1] <= pipe[0];
      pipe[2] <= pipe[1];
      if (if_parcel_valid_i) begin
        exp_nxt_pc <= exp_nxt_pc + 32'd4;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      assert (if_nxt_pc_o == exp_nxt_pc) else begin
        errors++;
        $display("** Error: if_nxt_pc_o expected %h actual %h", exp_nxt_pc, if_nxt_pc_o);
      end
      assert (wb_we_o == pipe[2].we) else begin
        errors++;
        $display("** Error: wb_we_o expected %h actual %h", pipe[2].we, wb_we_o);
      end
      if (pipe[2].we) begin
        assert (wb_dst_o == pipe[2].dst) else begin
          errors++;
          $display("** Error: wb_dst_o expected %h actual %h", pipe[2].dst, wb_dst_o);
        end
        assert (wb_r_o == pipe[2].r) else begin
          errors++;
          $display("** Error: wb_r_o expected %h actual %h", pipe[2].r, wb_r_o);
        end
        assert (wb_pc_o == pipe[2].pc) else begin
          errors++;
          $display("** Error: wb_pc_o expected %h actual %h", pipe[2].pc, wb_pc_o);
        end
      end
      if (wb_we_o) begin
        n_wb++;
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: test did not finish within %0d cycles", TIMEOUT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    int          issued;
    logic        prev_idle;
    logic [31:0] word;
    exp_t        res;
    void'($urandom(SEED));
    rst_n_i           = 1'b0;
    if_parcel_valid_i = 1'b0;
    if_parcel_i       = '0;
    drv_exp           = '0;
    errors            = 0;
    n_wb              = 0;
    n_exp_writes      = 0;
    cycles            = 0;
    issued            = 0;
    prev_idle         = 1'b0;
    for (int k = 0; k < 32; k++) begin
      ref_regs[k] = '0;
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) @(posedge clk_i);

    // Never two idle cycles in a row, so each instruction takes at most 2 cycles
    while (issued < N_INSTR) begin
      @(posedge clk_i);
      if (!prev_idle && $urandom_range(0, 2) == 0) begin
        if_parcel_valid_i <= 1'b0;
        if_parcel_i       <= $urandom;
        prev_idle = 1'b1;
      end else begin
        make_instruction(word, res);
        if_parcel_valid_i <= 1'b1;
        if_parcel_i       <= word;
        drv_exp           <= res;
        issued++;
        prev_idle = 1'b0;
      end
    end
    @(posedge clk_i);
    if_parcel_valid_i <= 1'b0;
    repeat (6) @(posedge clk_i);

    if (n_wb != n_exp_writes) begin
      errors++;
      $display("Write-back count wrong, saw %0d writes but %0d were issued", n_wb,
               n_exp_writes);
    end
    $display("Summary: %0d errors, %0d write-backs, %0d instructions issued", errors, n_wb,
             issued);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
